//--- build.f
src/mcu_pkg.sv
src/bus_arbiter.sv
src/ram_bank.sv
src/gpio_periph.sv
src/system_bus.sv
src/mini_mcu_top.sv
verification/mini_mcu_chk.sv
verification/mini_mcu_scoreboard.sv
verification/mini_mcu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module mini_mcu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/Vmini_mcu_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
exit 1

//--- src/bus_arbiter.sv
// round-robin arbiter for the bus masters
// combinational one-hot grant, registered priority pointer
module bus_arbiter #(
  parameter int N = 2
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic [N-1:0] req_i,
  output logic [N-1:0] gnt_o
);

  localparam int PW = (N > 1) ? $clog2(N) : 1;

  logic [PW-1:0] ptr_q;
  logic [PW-1:0] winner;
  logic          found;

  // search starts at the pointer and wraps around
  always_comb begin
    int idx;
    gnt_o  = '0;
    winner = ptr_q;
    found  = 1'b0;
    for (int i = 0; i < N; i++) begin
      idx = (int'(ptr_q) + i) % N;
      if (!found && req_i[idx]) begin
        gnt_o[idx] = 1'b1;
        winner     = PW'(idx);
        found      = 1'b1;
      end
    end
  end

  // move past the winner, only when something was granted
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= (int'(winner) == N - 1) ? '0 : winner + 1'b1;
    end
  end

endmodule

//--- src/gpio_periph.sv
// always-on GPIO: output, output-enable and interrupt registers
// two-flop input synchronizer, rising edge interrupt status
module gpio_periph #(
  parameter int WIDTH = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [mcu_pkg::BE_W-1:0]   be_i,
  input  mcu_pkg::gpio_reg_e         offset_i,
  input  logic [mcu_pkg::DATA_W-1:0] wdata_i,
  output logic [mcu_pkg::DATA_W-1:0] rdata_o,
  input  logic [WIDTH-1:0]           gpio_i,
  output logic [WIDTH-1:0]           gpio_o,
  output logic [WIDTH-1:0]           gpio_oe_o,
  output logic                       irq_o
);

  logic [WIDTH-1:0] out_q;
  logic [WIDTH-1:0] oe_q;
  logic [WIDTH-1:0] intr_en_q;
  logic [WIDTH-1:0] status_q;
  logic [WIDTH-1:0] sync1_q;
  logic [WIDTH-1:0] sync2_q;
  logic [WIDTH-1:0] prev_q;
  logic [WIDTH-1:0] rise;
  logic [WIDTH-1:0] wbits;
  logic [WIDTH-1:0] mbits;
  logic [WIDTH-1:0] clr;
  logic [mcu_pkg::DATA_W-1:0] wmask;
  logic             wr;

  always_comb begin
    for (int b = 0; b < mcu_pkg::BE_W; b++) begin
      wmask[8*b +: 8] = {8{be_i[b]}};
    end
  end

  assign wbits = WIDTH'(wdata_i & wmask);
  assign mbits = WIDTH'(wmask);
  assign wr    = req_i && we_i;
  assign rise  = sync2_q & ~prev_q;
  // write 1 to clear
  assign clr   = (wr && offset_i == mcu_pkg::GPIO_INTR_STATUS) ? wbits : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      // a fresh edge beats a clear in the same cycle
      status_q <= (status_q & ~clr) | (rise & intr_en_q);
      if (wr) begin
        case (offset_i)
          mcu_pkg::GPIO_OUT:     out_q     <= (out_q & ~mbits) | wbits;
          mcu_pkg::GPIO_OE:      oe_q      <= (oe_q & ~mbits) | wbits;
          mcu_pkg::GPIO_INTR_EN: intr_en_q <= (intr_en_q & ~mbits) | wbits;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        case (offset_i)
          mcu_pkg::GPIO_OUT:         rdata_o <= mcu_pkg::DATA_W'(out_q);
          mcu_pkg::GPIO_OE:          rdata_o <= mcu_pkg::DATA_W'(oe_q);
          mcu_pkg::GPIO_IN:          rdata_o <= mcu_pkg::DATA_W'(sync2_q);
          mcu_pkg::GPIO_INTR_EN:     rdata_o <= mcu_pkg::DATA_W'(intr_en_q);
          mcu_pkg::GPIO_INTR_STATUS: rdata_o <= mcu_pkg::DATA_W'(status_q);
          default:                   rdata_o <= '0;
        endcase
      end
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign irq_o     = |status_q;

endmodule

//--- src/mcu_pkg.sv
// shared bus widths, address map and default sizes
// slave select and GPIO register offset enums
package mcu_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int BE_W        = 4;
  localparam int NUM_MASTERS = 2;

  // sizes the top level hands down
  localparam int DEFAULT_NUM_BANKS  = 2;
  localparam int DEFAULT_BANK_WORDS = 256;
  localparam int DEFAULT_GPIO_WIDTH = 8;

  // RAM region, NUM_BANKS x BANK_WORDS words from address zero
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK =
    ADDR_W'(DEFAULT_NUM_BANKS * DEFAULT_BANK_WORDS * 4 - 1);

  // always-on GPIO block
  localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] GPIO_SIZE = 32'h0000_0100;

  typedef enum logic [1:0] {
    SLV_RAM,
    SLV_GPIO,
    SLV_NONE
  } slave_sel_e;

  typedef enum logic [7:0] {
    GPIO_OUT         = 8'h00,
    GPIO_OE          = 8'h04,
    GPIO_IN          = 8'h08,
    GPIO_INTR_EN     = 8'h0C,
    GPIO_INTR_STATUS = 8'h10
  } gpio_reg_e;

endpackage

//--- src/mini_mcu_top.sv
// top level: system bus, interleaved RAM banks, always-on GPIO
module mini_mcu_top #(
  parameter int NUM_BANKS  = mcu_pkg::DEFAULT_NUM_BANKS,
  parameter int BANK_WORDS = mcu_pkg::DEFAULT_BANK_WORDS,
  parameter int GPIO_WIDTH = mcu_pkg::DEFAULT_GPIO_WIDTH
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                       m_req_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::ADDR_W-1:0]  m_addr_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                       m_we_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::BE_W-1:0]    m_be_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::DATA_W-1:0]  m_wdata_i,
  output logic [mcu_pkg::NUM_MASTERS-1:0]                       m_gnt_o,
  output logic [mcu_pkg::NUM_MASTERS-1:0]                       m_rvalid_o,
  output logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::DATA_W-1:0]  m_rdata_o,
  input  logic [GPIO_WIDTH-1:0]                                 gpio_i,
  output logic [GPIO_WIDTH-1:0]                                 gpio_o,
  output logic [GPIO_WIDTH-1:0]                                 gpio_oe_o,
  output logic                                                  irq_o
);

  localparam int WORD_W = $clog2(BANK_WORDS);

  logic [NUM_BANKS-1:0]                         ram_req;
  logic                                         ram_we;
  logic [mcu_pkg::BE_W-1:0]                     ram_be;
  logic [WORD_W-1:0]                            ram_addr;
  logic [mcu_pkg::DATA_W-1:0]                   ram_wdata;
  logic [NUM_BANKS-1:0][mcu_pkg::DATA_W-1:0]    ram_rdata;
  logic                                         gpio_req;
  logic                                         gpio_we;
  logic [mcu_pkg::BE_W-1:0]                     gpio_be;
  mcu_pkg::gpio_reg_e                           gpio_offset;
  logic [mcu_pkg::DATA_W-1:0]                   gpio_wdata;
  logic [mcu_pkg::DATA_W-1:0]                   gpio_rdata;

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) system_bus_i (
    .clk_i,
    .rst_n_i,
    .m_req_i,
    .m_addr_i,
    .m_we_i,
    .m_be_i,
    .m_wdata_i,
    .m_gnt_o,
    .m_rvalid_o,
    .m_rdata_o,
    .ram_req_o    (ram_req),
    .ram_we_o     (ram_we),
    .ram_be_o     (ram_be),
    .ram_addr_o   (ram_addr),
    .ram_wdata_o  (ram_wdata),
    .ram_rdata_i  (ram_rdata),
    .gpio_req_o   (gpio_req),
    .gpio_we_o    (gpio_we),
    .gpio_be_o    (gpio_be),
    .gpio_offset_o(gpio_offset),
    .gpio_wdata_o (gpio_wdata),
    .gpio_rdata_i (gpio_rdata)
  );

  // one bank per interleave slot
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_ram_bank
    ram_bank #(
      .WORDS(BANK_WORDS)
    ) ram_bank_i (
      .clk_i,
      .req_i  (ram_req[b]),
      .we_i   (ram_we),
      .be_i   (ram_be),
      .addr_i (ram_addr),
      .wdata_i(ram_wdata),
      .rdata_o(ram_rdata[b])
    );
  end

  gpio_periph #(
    .WIDTH(GPIO_WIDTH)
  ) gpio_periph_i (
    .clk_i,
    .rst_n_i,
    .req_i    (gpio_req),
    .we_i     (gpio_we),
    .be_i     (gpio_be),
    .offset_i (gpio_offset),
    .wdata_i  (gpio_wdata),
    .rdata_o  (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_o
  );

endmodule

//--- src/ram_bank.sv
// single SRAM bank, byte-enabled write, registered read
// writes answer with zero data
module ram_bank #(
  parameter int WORDS = 256
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [3:0]               be_i,
  input  logic [$clog2(WORDS)-1:0] addr_i,
  input  logic [31:0]              wdata_i,
  output logic [31:0]              rdata_o
);

  logic [31:0] mem [WORDS];

  // byte lanes
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // read port, held until the next access
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- src/system_bus.sv
// OBI system bus: arbitration, address decode, request steering
// response return to the registered owner one cycle after grant
module system_bus #(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 256
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                       m_req_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::ADDR_W-1:0]  m_addr_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                       m_we_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::BE_W-1:0]    m_be_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::DATA_W-1:0]  m_wdata_i,
  output logic [mcu_pkg::NUM_MASTERS-1:0]                       m_gnt_o,
  output logic [mcu_pkg::NUM_MASTERS-1:0]                       m_rvalid_o,
  output logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::DATA_W-1:0]  m_rdata_o,
  output logic [NUM_BANKS-1:0]                                  ram_req_o,
  output logic                                                  ram_we_o,
  output logic [mcu_pkg::BE_W-1:0]                              ram_be_o,
  output logic [$clog2(BANK_WORDS)-1:0]                         ram_addr_o,
  output logic [mcu_pkg::DATA_W-1:0]                            ram_wdata_o,
  input  logic [NUM_BANKS-1:0][mcu_pkg::DATA_W-1:0]             ram_rdata_i,
  output logic                                                  gpio_req_o,
  output logic                                                  gpio_we_o,
  output logic [mcu_pkg::BE_W-1:0]                              gpio_be_o,
  output mcu_pkg::gpio_reg_e                                    gpio_offset_o,
  output logic [mcu_pkg::DATA_W-1:0]                            gpio_wdata_o,
  input  logic [mcu_pkg::DATA_W-1:0]                            gpio_rdata_i
);

  localparam int MW        = (mcu_pkg::NUM_MASTERS > 1) ? $clog2(mcu_pkg::NUM_MASTERS) : 1;
  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int BANK_W    = (BANK_BITS > 0) ? BANK_BITS : 1;
  localparam int WORD_W    = $clog2(BANK_WORDS);

  logic [mcu_pkg::NUM_MASTERS-1:0] gnt;
  logic                            any_gnt;
  logic [MW-1:0]                   sel_idx;
  logic [mcu_pkg::ADDR_W-1:0]      addr_sel;
  logic [BANK_W-1:0]               bank_idx;
  mcu_pkg::slave_sel_e             slave;
  logic [mcu_pkg::DATA_W-1:0]      resp_data;

  // response owner
  logic                            rvalid_q;
  logic [MW-1:0]                   owner_q;
  mcu_pkg::slave_sel_e             target_q;
  logic [BANK_W-1:0]               bank_q;

  bus_arbiter #(
    .N(mcu_pkg::NUM_MASTERS)
  ) bus_arbiter_i (
    .clk_i,
    .rst_n_i,
    .req_i(m_req_i),
    .gnt_o(gnt)
  );

  assign m_gnt_o = gnt;
  assign any_gnt = |gnt;

  always_comb begin
    sel_idx = '0;
    for (int m = 0; m < mcu_pkg::NUM_MASTERS; m++) begin
      if (gnt[m]) sel_idx = MW'(m);
    end
  end

  assign addr_sel = m_addr_i[sel_idx];
  // banks interleave on the lowest word address bits
  assign bank_idx = (BANK_BITS > 0) ? addr_sel[2 +: BANK_W] : '0;

  always_comb begin
    slave = mcu_pkg::SLV_NONE;
    if ((addr_sel & ~mcu_pkg::RAM_MASK) == mcu_pkg::RAM_BASE) begin
      slave = mcu_pkg::SLV_RAM;
    end else if (addr_sel >= mcu_pkg::GPIO_BASE &&
                 addr_sel < mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_SIZE) begin
      slave = mcu_pkg::SLV_GPIO;
    end
  end

  always_comb begin
    ram_req_o = '0;
    if (any_gnt && slave == mcu_pkg::SLV_RAM) ram_req_o[bank_idx] = 1'b1;
  end

  assign ram_we_o      = m_we_i[sel_idx];
  assign ram_be_o      = m_be_i[sel_idx];
  assign ram_addr_o    = addr_sel[2 + BANK_BITS +: WORD_W];
  assign ram_wdata_o   = m_wdata_i[sel_idx];
  assign gpio_req_o    = any_gnt && slave == mcu_pkg::SLV_GPIO;
  assign gpio_we_o     = m_we_i[sel_idx];
  assign gpio_be_o     = m_be_i[sel_idx];
  assign gpio_offset_o = mcu_pkg::gpio_reg_e'(addr_sel[7:0]);
  assign gpio_wdata_o  = m_wdata_i[sel_idx];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      owner_q  <= '0;
      target_q <= mcu_pkg::SLV_NONE;
      bank_q   <= '0;
    end else begin
      rvalid_q <= any_gnt;
      if (any_gnt) begin
        owner_q  <= sel_idx;
        target_q <= slave;
        bank_q   <= bank_idx;
      end
    end
  end

  always_comb begin
    case (target_q)
      mcu_pkg::SLV_RAM:  resp_data = ram_rdata_i[bank_q];
      mcu_pkg::SLV_GPIO: resp_data = gpio_rdata_i;
      default:           resp_data = '0;
    endcase
  end

  // only the owner sees the response
  always_comb begin
    for (int m = 0; m < mcu_pkg::NUM_MASTERS; m++) begin
      m_rvalid_o[m] = rvalid_q && owner_q == MW'(m);
      m_rdata_o[m]  = m_rvalid_o[m] ? resp_data : '0;
    end
  end

endmodule

//--- verification/mini_mcu_chk.sv
// concurrent checks on the OBI master handshake, bound to the system bus
module mini_mcu_chk #(
  parameter int NM = 2
) (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic [NM-1:0]                      req_i,
  input logic [NM-1:0][mcu_pkg::ADDR_W-1:0] addr_i,
  input logic [NM-1:0]                      we_i,
  input logic [NM-1:0][mcu_pkg::BE_W-1:0]   be_i,
  input logic [NM-1:0][mcu_pkg::DATA_W-1:0] wdata_i,
  input logic [NM-1:0]                      gnt_i,
  input logic [NM-1:0]                      rvalid_i
);

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_i)) else $error("grant vector is not one-hot");

  for (genvar m = 0; m < NM; m++) begin : gen_port
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt_i[m] |=> rvalid_i[m]) else $error("no rvalid one cycle after grant");

    a_no_lone_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i[m] |-> $past(gnt_i[m])) else $error("rvalid without a grant");

    // request fields frozen while waiting for the grant
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i[m] && !gnt_i[m] |=> req_i[m] && $stable(addr_i[m]) && $stable(we_i[m])
        && $stable(be_i[m]) && $stable(wdata_i[m]))
      else $error("request dropped or changed before grant");
  end

endmodule

//--- verification/mini_mcu_scoreboard.sv
// reference model of RAM bytes, GPIO registers and arbiter pointer
// compares every response, grant and GPIO pin against the model
module mini_mcu_scoreboard #(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 256,
  parameter int GPIO_WIDTH = 8
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                      req_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::ADDR_W-1:0] addr_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                      we_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::BE_W-1:0]   be_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::DATA_W-1:0] wdata_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                      gnt_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0]                      rvalid_i,
  input  logic [mcu_pkg::NUM_MASTERS-1:0][mcu_pkg::DATA_W-1:0] rdata_i,
  input  logic [GPIO_WIDTH-1:0]                                gpio_in_i,
  input  logic [GPIO_WIDTH-1:0]                                gpio_out_i,
  input  logic [GPIO_WIDTH-1:0]                                gpio_oe_i,
  input  logic                                                 irq_i,
  output int                                                   tests_o,
  output int                                                   errors_o
);

  localparam int          NM        = mcu_pkg::NUM_MASTERS;
  localparam logic [31:0] RAM_BYTES = 32'(NUM_BANKS * BANK_WORDS * 4);

  logic [7:0]            ram_model [logic [31:0]];
  logic [GPIO_WIDTH-1:0] out_m;
  logic [GPIO_WIDTH-1:0] oe_m;
  logic [GPIO_WIDTH-1:0] en_m;
  logic [GPIO_WIDTH-1:0] status_m;
  logic [GPIO_WIDTH-1:0] s1_m;
  logic [GPIO_WIDTH-1:0] s2_m;
  logic [GPIO_WIDTH-1:0] prev_m;
  int                    ptr;
  logic                  pend;
  int                    pend_m;
  logic                  pend_we;
  logic [31:0]           pend_addr;
  logic [31:0]           pend_exp;
  logic [31:0]           pend_mask;
  int                    tests = 0;
  int                    errors = 0;

  assign tests_o  = tests;
  assign errors_o = errors;

  task automatic report(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors++;
  endtask

  // model state leads the DUT by one rising edge
  always @(negedge clk_i) begin
    logic [NM-1:0]         exp_gnt;
    logic [NM-1:0]         exp_rvalid;
    logic [NM-1:0]         xfer;
    logic [GPIO_WIDTH-1:0] wbits;
    logic [GPIO_WIDTH-1:0] mbits;
    logic [GPIO_WIDTH-1:0] clr;
    logic [GPIO_WIDTH-1:0] rise_en;
    logic [31:0]           a;
    logic [31:0]           key;
    logic [31:0]           bmask;
    int                    m;
    int                    idx;
    if (!rst_n_i) begin
      out_m    = '0;
      oe_m     = '0;
      en_m     = '0;
      status_m = '0;
      s1_m     = '0;
      s2_m     = '0;
      prev_m   = '0;
      ptr      = 0;
      pend     = 1'b0;
      if (rvalid_i !== '0 || gpio_out_i !== '0 || gpio_oe_i !== '0 || irq_i !== 1'b0) begin
        report("outputs not idle during reset");
      end
    end else begin
      exp_rvalid = pend ? NM'(1 << pend_m) : '0;
      if (rvalid_i !== exp_rvalid) begin
        report($sformatf("rvalid %b, expected %b", rvalid_i, exp_rvalid));
      end else if (pend) begin
        tests++;
        if ((rdata_i[pend_m] & pend_mask) !== (pend_exp & pend_mask)) begin
          report($sformatf("master %0d %s addr %h rdata %h, expected %h", pend_m,
                           pend_we ? "write" : "read", pend_addr, rdata_i[pend_m], pend_exp));
        end else begin
          $display("test %0d: master %0d %s addr %h rdata %h ok", tests, pend_m,
                   pend_we ? "write" : "read", pend_addr, rdata_i[pend_m]);
        end
      end

      // round-robin search starts after the last winner
      exp_gnt = '0;
      for (int i = 0; i < NM; i++) begin
        idx = (ptr + i) % NM;
        if (exp_gnt == '0 && req_i[idx]) exp_gnt[idx] = 1'b1;
      end
      if (gnt_i !== exp_gnt) begin
        report($sformatf("gnt %b with req %b, expected %b", gnt_i, req_i, exp_gnt));
      end

      if (gpio_out_i !== out_m || gpio_oe_i !== oe_m || irq_i !== (|status_m)) begin
        report($sformatf("gpio_o %h oe %h irq %b, expected %h %h %b", gpio_out_i,
                         gpio_oe_i, irq_i, out_m, oe_m, |status_m));
      end

      rise_en = s2_m & ~prev_m & en_m;
      clr     = '0;
      pend    = 1'b0;
      xfer    = req_i & gnt_i;
      if (xfer != '0) begin
        m = 0;
        for (int i = 0; i < NM; i++) begin
          if (xfer[i]) m = i;
        end
        a         = addr_i[m];
        pend      = 1'b1;
        pend_m    = m;
        pend_we   = we_i[m];
        pend_addr = a;
        pend_exp  = '0;
        pend_mask = '1;
        for (int b = 0; b < 4; b++) begin
          bmask[8*b +: 8] = {8{be_i[m][b]}};
        end
        wbits = GPIO_WIDTH'(wdata_i[m] & bmask);
        mbits = GPIO_WIDTH'(bmask);
        if (a < RAM_BYTES) begin
          for (int b = 0; b < 4; b++) begin
            key = {a[31:2], 2'(b)};
            if (we_i[m]) begin
              if (be_i[m][b]) ram_model[key] = wdata_i[m][8*b +: 8];
            end else if (ram_model.exists(key)) begin
              pend_exp[8*b +: 8] = ram_model[key];
            end else begin
              // bytes never written are undefined
              pend_mask[8*b +: 8] = 8'h00;
            end
          end
        end else if (a >= mcu_pkg::GPIO_BASE &&
                     a < mcu_pkg::GPIO_BASE + mcu_pkg::GPIO_SIZE) begin
          if (we_i[m]) begin
            case (a[7:0])
              mcu_pkg::GPIO_OUT:         out_m = (out_m & ~mbits) | wbits;
              mcu_pkg::GPIO_OE:          oe_m = (oe_m & ~mbits) | wbits;
              mcu_pkg::GPIO_INTR_EN:     en_m = (en_m & ~mbits) | wbits;
              mcu_pkg::GPIO_INTR_STATUS: clr = wbits;
              default: ;
            endcase
          end else begin
            case (a[7:0])
              mcu_pkg::GPIO_OUT:         pend_exp = 32'(out_m);
              mcu_pkg::GPIO_OE:          pend_exp = 32'(oe_m);
              mcu_pkg::GPIO_IN:          pend_exp = 32'(s2_m);
              mcu_pkg::GPIO_INTR_EN:     pend_exp = 32'(en_m);
              mcu_pkg::GPIO_INTR_STATUS: pend_exp = 32'(status_m);
              default:                   pend_exp = '0;
            endcase
          end
        end
        ptr = (m + 1) % NM;
      end

      // edge wins over a clear in the same cycle
      status_m = (status_m & ~clr) | rise_en;
      prev_m   = s2_m;
      s2_m     = s1_m;
      s1_m     = gpio_in_i;
    end
  end

endmodule

//--- verification/mini_mcu_tb.sv
// testbench top with clock, reset, stimulus table, driver loop and watchdog
// scoreboard compares and a bound checker watches the bus handshake
module mini_mcu_tb;

  localparam int          NB          = mcu_pkg::DEFAULT_NUM_BANKS;
  localparam int          BW          = mcu_pkg::DEFAULT_BANK_WORDS;
  localparam int          GW          = mcu_pkg::DEFAULT_GPIO_WIDTH;
  localparam int          NM          = mcu_pkg::NUM_MASTERS;
  localparam int          MAX_ENTRIES = 64;
  localparam logic [31:0] GB          = mcu_pkg::GPIO_BASE;

  logic                                  clk;
  logic                                  rst_n;
  logic [NM-1:0]                         req;
  logic [NM-1:0][mcu_pkg::ADDR_W-1:0]    addr;
  logic [NM-1:0]                         we;
  logic [NM-1:0][mcu_pkg::BE_W-1:0]      be;
  logic [NM-1:0][mcu_pkg::DATA_W-1:0]    wdata;
  logic [NM-1:0]                         gnt;
  logic [NM-1:0]                         rvalid;
  logic [NM-1:0][mcu_pkg::DATA_W-1:0]    rdata;
  logic [GW-1:0]                         gpio_in;
  logic [GW-1:0]                         gpio_out;
  logic [GW-1:0]                         gpio_oe;
  logic                                  irq;
  int                                    tests;
  int                                    errors;
  int                                    driver_errors;
  int                                    num_entries;
  logic                                  table_ready;
  int                                    seed;
  int                                    e;

  // stimulus table with one transfer per row
  int          t_master [MAX_ENTRIES];
  logic        t_we     [MAX_ENTRIES];
  logic [31:0] t_addr   [MAX_ENTRIES];
  logic [3:0]  t_be     [MAX_ENTRIES];
  logic [31:0] t_wdata  [MAX_ENTRIES];
  logic [GW-1:0] t_gpio [MAX_ENTRIES];
  logic        t_par    [MAX_ENTRIES];

  mini_mcu_top #(
    .NUM_BANKS (NB),
    .BANK_WORDS(BW),
    .GPIO_WIDTH(GW)
  ) UUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .m_req_i   (req),
    .m_addr_i  (addr),
    .m_we_i    (we),
    .m_be_i    (be),
    .m_wdata_i (wdata),
    .m_gnt_o   (gnt),
    .m_rvalid_o(rvalid),
    .m_rdata_o (rdata),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .irq_o     (irq)
  );

  mini_mcu_scoreboard #(
    .NUM_BANKS (NB),
    .BANK_WORDS(BW),
    .GPIO_WIDTH(GW)
  ) scoreboard_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .req_i     (req),
    .addr_i    (addr),
    .we_i      (we),
    .be_i      (be),
    .wdata_i   (wdata),
    .gnt_i     (gnt),
    .rvalid_i  (rvalid),
    .rdata_i   (rdata),
    .gpio_in_i (gpio_in),
    .gpio_out_i(gpio_out),
    .gpio_oe_i (gpio_oe),
    .irq_i     (irq),
    .tests_o   (tests),
    .errors_o  (errors)
  );

  bind system_bus mini_mcu_chk #(
    .NM(mcu_pkg::NUM_MASTERS)
  ) chk_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (m_req_i),
    .addr_i  (m_addr_i),
    .we_i    (m_we_i),
    .be_i    (m_be_i),
    .wdata_i (m_wdata_i),
    .gnt_i   (m_gnt_o),
    .rvalid_i(m_rvalid_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic add_entry(input int m, input logic w, input logic [31:0] a,
                           input logic [3:0] b, input logic [31:0] d,
                           input logic [GW-1:0] g, input logic par);
    t_master[num_entries] = m;
    t_we[num_entries]     = w;
    t_addr[num_entries]   = a;
    t_be[num_entries]     = b;
    t_wdata[num_entries]  = d;
    t_gpio[num_entries]   = g;
    t_par[num_entries]    = par;
    num_entries++;
  endtask

  task automatic build_table();
    // bulk words spread over both banks
    for (int i = 0; i < 8; i++) begin
      add_entry(i % 2, 1'b1, 32'(i * 4), 4'hF, $random(seed), 8'h00, 1'b0);
    end
    add_entry(0, 1'b1, 32'h0000_0004, 4'h3, 32'hDEAD_BEEF, 8'h00, 1'b0);
    add_entry(1, 1'b1, 32'h0000_0008, 4'hC, 32'hCAFE_F00D, 8'h00, 1'b0);
    add_entry(0, 1'b1, 32'h0000_0010, 4'h5, 32'h1122_3344, 8'h00, 1'b0);
    add_entry(1, 1'b1, 32'h0000_07FC, 4'hF, 32'hA5A5_0F0F, 8'h00, 1'b0);
    for (int i = 0; i < 8; i++) begin
      add_entry(i % 2, 1'b0, 32'(i * 4), 4'hF, 32'h0, 8'h00, 1'b0);
    end
    add_entry(1, 1'b0, 32'h0000_07FC, 4'hF, 32'h0, 8'h00, 1'b0);
    // both masters at once
    add_entry(0, 1'b0, 32'h0000_0000, 4'hF, 32'h0, 8'h00, 1'b1);
    add_entry(1, 1'b0, 32'h0000_0004, 4'hF, 32'h0, 8'h00, 1'b0);
    add_entry(1, 1'b0, 32'h0000_0010, 4'hF, 32'h0, 8'h00, 1'b0);
    add_entry(0, 1'b0, 32'h0000_0014, 4'hF, 32'h0, 8'h00, 1'b0);
    add_entry(0, 1'b1, 32'h0000_0018, 4'hF, 32'h0102_0304, 8'h00, 1'b1);
    add_entry(1, 1'b1, 32'h0000_001C, 4'hF, 32'h0506_0708, 8'h00, 1'b0);
    add_entry(0, 1'b0, 32'h0000_0018, 4'hF, 32'h0, 8'h00, 1'b1);
    add_entry(1, 1'b0, 32'h0000_001C, 4'hF, 32'h0, 8'h00, 1'b0);
    // GPIO outputs and input path
    add_entry(0, 1'b1, GB + 32'h00, 4'h1, 32'h0000_005A, 8'h00, 1'b0);
    add_entry(1, 1'b1, GB + 32'h04, 4'h1, 32'h0000_00F0, 8'h00, 1'b0);
    add_entry(0, 1'b0, GB + 32'h00, 4'hF, 32'h0, 8'h00, 1'b0);
    add_entry(1, 1'b0, GB + 32'h04, 4'hF, 32'h0, 8'h00, 1'b0);
    add_entry(0, 1'b1, GB + 32'h08, 4'h1, 32'h0000_00FF, 8'hA5, 1'b0);
    add_entry(1, 1'b0, GB + 32'h08, 4'hF, 32'h0, 8'hA5, 1'b0);
    add_entry(0, 1'b0, GB + 32'h08, 4'hF, 32'h0, 8'hA5, 1'b0);
    // edge interrupt on bit 0 only
    add_entry(0, 1'b0, GB + 32'h10, 4'hF, 32'h0, 8'h00, 1'b0);
    add_entry(0, 1'b1, GB + 32'h0C, 4'h1, 32'h0000_0001, 8'h00, 1'b0);
    add_entry(1, 1'b0, GB + 32'h0C, 4'hF, 32'h0, 8'h01, 1'b0);
    add_entry(0, 1'b0, GB + 32'h10, 4'hF, 32'h0, 8'h01, 1'b0);
    add_entry(1, 1'b0, GB + 32'h10, 4'hF, 32'h0, 8'h01, 1'b0);
    add_entry(0, 1'b1, GB + 32'h10, 4'h1, 32'h0000_0001, 8'h01, 1'b0);
    add_entry(1, 1'b0, GB + 32'h10, 4'hF, 32'h0, 8'h01, 1'b0);
    add_entry(0, 1'b0, GB + 32'h10, 4'hF, 32'h0, 8'h81, 1'b0);
    add_entry(1, 1'b0, GB + 32'h10, 4'hF, 32'h0, 8'h81, 1'b0);
    // unmapped space
    add_entry(0, 1'b0, 32'h1000_0000, 4'hF, 32'h0, 8'h81, 1'b0);
    add_entry(1, 1'b1, 32'h1000_0000, 4'hF, 32'hFFFF_FFFF, 8'h81, 1'b0);
    add_entry(0, 1'b1, 32'h0000_0800, 4'hF, 32'h7777_7777, 8'h81, 1'b0);
    add_entry(1, 1'b0, 32'h0000_0800, 4'hF, 32'h0, 8'h81, 1'b0);
    add_entry(0, 1'b0, GB + 32'h20, 4'hF, 32'h0, 8'h81, 1'b0);
    add_entry(1, 1'b1, 32'h3000_0000, 4'hF, 32'h1234_5678, 8'h81, 1'b0);
    add_entry(0, 1'b0, 32'h0000_0000, 4'hF, 32'h0, 8'h81, 1'b0);
    add_entry(1, 1'b0, GB + 32'h00, 4'hF, 32'h0, 8'h81, 1'b0);
  endtask

  // request, hold until granted, then expect rvalid one cycle later
  task automatic run_transfer(input int idx);
    int m;
    int wait_cycles;
    m          = t_master[idx];
    req[m]     = 1'b1;
    addr[m]    = t_addr[idx];
    we[m]      = t_we[idx];
    be[m]      = t_be[idx];
    wdata[m]   = t_wdata[idx];
    wait_cycles = 0;
    @(negedge clk);
    while (!gnt[m] && wait_cycles < 16) begin
      wait_cycles++;
      @(negedge clk);
    end
    if (!gnt[m]) begin
      $display("entry %0d: master %0d was never granted", idx, m);
      driver_errors++;
    end
    @(posedge clk);
    #1;
    req[m] = 1'b0;
    @(negedge clk);
    if (!rvalid[m]) begin
      $display("entry %0d: master %0d got no rvalid after its grant", idx, m);
      driver_errors++;
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    req           = '0;
    addr          = '0;
    we            = '0;
    be            = '0;
    wdata         = '0;
    gpio_in       = '0;
    driver_errors = 0;
    num_entries   = 0;
    table_ready   = 1'b0;
    seed          = 80;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);

    e = 0;
    while (e < num_entries) begin
      @(posedge clk);
      #1;
      gpio_in = t_gpio[e];
      if (t_par[e] && e + 1 < num_entries) begin
        fork
          run_transfer(e);
          run_transfer(e + 1);
        join
        e += 2;
      end else begin
        run_transfer(e);
        e++;
      end
    end
    repeat (4) @(posedge clk);

    $display("tests %0d of %0d, mismatches %0d, driver errors %0d",
             tests, num_entries, errors, driver_errors);
    if (errors == 0 && driver_errors == 0 && tests == num_entries) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready);
    repeat (num_entries * 20 + 200) @(posedge clk);
    $display("timed out: run did not finish within %0d cycles", num_entries * 20 + 200);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
